//--- Bender.yml
package:
  name: audio_mixer

sources:
  # packages first
  - verilog/mixer_pkg.sv
  - verilog/axi4l_pkg.sv
  - verilog/nq_multiplier.sv
  - verilog/mixer_channel.sv
  - verilog/mixer_core.sv
  - verilog/mixer_regs.sv
  - verilog/audio_mixer_top.sv
  - target: test
    files:
      - tb/mixer_checker.sv
      - tb/tb_audio_mixer.sv

//--- src.f
verilog/mixer_pkg.sv
verilog/axi4l_pkg.sv
verilog/nq_multiplier.sv
verilog/mixer_channel.sv
verilog/mixer_core.sv
verilog/mixer_regs.sv
verilog/audio_mixer_top.sv
tb/mixer_checker.sv
tb/tb_audio_mixer.sv

//--- tb/mixer_checker.sv
`timescale 1ns/1ps

module mixer_checker (
  input  logic                  clk,
  input  logic                  rst_n,
  input  axi4l_pkg::axi4l_req_t axi_req,
  input  axi4l_pkg::axi4l_rsp_t axi_rsp,
  input  mixer_pkg::mix_frame_t in_frame,
  input  logic                  in_valid,
  input  logic                  in_ready,
  input  mixer_pkg::stereo_t    out_sample,
  input  logic                  out_valid,
  input  logic                  out_ready,
  output int                    errors,
  output int                    pending
);

  import mixer_pkg::*;

  typedef struct packed {
    stereo_t     sample;
    int unsigned cycle;    // accept cycle
    int unsigned stalls;   // stall count at accept
  } expect_t;

  expect_t     exp_q[$];
  expect_t     head;
  expect_t     entry;
  mix_cfg_t    shadow;     // config as seen on the bus
  int unsigned cycle;
  int unsigned stalls;

  function automatic audio_t clamp(longint v);
    if (v > 32767) begin
      return 16'sh7fff;
    end
    if (v < -32768) begin
      return 16'sh8000;
    end
    return audio_t'(v);
  endfunction

  // q8.8 gain per lane, hard pan, then common output gain
  function automatic stereo_t mix_model(mix_frame_t f, mix_cfg_t c);
    longint  bus_l;
    longint  bus_r;
    longint  lane;
    stereo_t s;
    bus_l = 0;
    bus_r = 0;
    for (int i = 0; i < nr_channels; i++) begin
      lane = clamp((longint'(f.ch[i]) * longint'(c.ch_gain[i])) >>> q_bits);
      if (c.pan[i]) begin
        bus_r += lane;
      end else begin
        bus_l += lane;
      end
    end
    s.left  = clamp((bus_l * longint'(c.out_gain)) >>> q_bits);
    s.right = clamp((bus_r * longint'(c.out_gain)) >>> q_bits);
    return s;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exp_q.delete();
      shadow.ch_gain  = {nr_channels{16'h0100}};
      shadow.pan      = '0;
      shadow.out_gain = 16'h0100;
      cycle   = 0;
      stalls  = 0;
      errors  = 0;
      pending = 0;
    end else begin
      if (out_valid && out_ready) begin
        if (exp_q.size() == 0) begin
          errors++;
          $display("Output sample arrived with no frame outstanding at cycle %0d", cycle);
        end else begin
          head = exp_q.pop_front();
          if (out_sample.left !== head.sample.left) begin
            errors++;
            $display("Mismatch out_sample.left: got 0x%h expected 0x%h",
                     out_sample.left, head.sample.left);
          end
          if (out_sample.right !== head.sample.right) begin
            errors++;
            $display("Mismatch out_sample.right: got 0x%h expected 0x%h",
                     out_sample.right, head.sample.right);
          end
          // only frames that never saw out_ready low
          if (head.stalls == stalls && cycle - head.cycle != 4) begin
            errors++;
            $display("Frame took %0d cycles through the pipeline instead of 4",
                     cycle - head.cycle);
          end
        end
      end
      if (in_valid && in_ready) begin
        entry.sample = mix_model(in_frame, shadow);
        entry.cycle  = cycle;
        entry.stalls = stalls;
        exp_q.push_back(entry);
      end
      if (axi_req.awvalid && axi_req.wvalid && axi_rsp.awready) begin
        case (axi_req.awaddr)
          reg_ch_gain0, reg_ch_gain1, reg_ch_gain2, reg_ch_gain3:
            shadow.ch_gain[axi_req.awaddr[3:2]] = axi_req.wdata[15:0];
          reg_pan:      shadow.pan = axi_req.wdata[nr_channels-1:0];
          reg_out_gain: shadow.out_gain = axi_req.wdata[15:0];
          default: ;
        endcase
      end
      if (in_ready !== (!out_valid || out_ready)) begin
        errors++;
        $display("in_ready does not follow the output stall at cycle %0d", cycle);
      end
      if (!out_ready) begin
        stalls++;
      end
      cycle++;
      pending = exp_q.size();
    end
  end

endmodule

//--- tb/tb_audio_mixer.sv
`timescale 1ns/1ps

module tb_audio_mixer;

  import mixer_pkg::*;
  import axi4l_pkg::*;

  typedef struct packed {
    gain_t [nr_channels-1:0] gains;       // ch3 first
    logic  [nr_channels-1:0] pan;
    gain_t                   out_gain;
    int                      frames;
    int                      duty;        // percent of cycles with out_ready high
    logic  [15:0]            level;       // sample magnitude
    bit                      fixed;       // +level/-level frames instead of random
    logic  [31:0]            exp_status;
  } row_t;

  localparam int nr_rows = 6;

  row_t rows [nr_rows] = '{
    '{{16'h0100, 16'h0100, 16'h0100, 16'h0100}, 4'b1010, 16'h0100, 16, 100, 16'h3fff, 1'b0, 32'h00},
    '{{16'h0100, 16'h0100, 16'h0200, 16'h0200}, 4'b1010, 16'h0080, 16, 100, 16'h6000, 1'b1, 32'h06},
    '{{16'h0100, 16'h0100, 16'h0100, 16'h0100}, 4'b0000, 16'h0100, 16, 100, 16'h7000, 1'b1, 32'h01},
    '{{16'h0100, 16'h0100, 16'h0100, 16'h0100}, 4'b0000, 16'h0080, 16, 100, 16'h3fff, 1'b0, 32'h00},
    '{{16'h0100, 16'h0100, 16'h0100, 16'h0100}, 4'b1100, 16'h0100, 40, 70, 16'h3fff, 1'b0, 32'h00},
    '{{16'h00ff, 16'h0100, 16'h0040, 16'h0180}, 4'b0110, 16'h0100, 8, 100, 16'h1fff, 1'b0, 32'h00}
  };

  logic       clk;
  logic       rst_n;
  axi4l_req_t axi_req;
  axi4l_rsp_t axi_rsp;
  mix_frame_t in_frame;
  logic       in_valid;
  logic       in_ready;
  stereo_t    out_sample;
  logic       out_valid;
  logic       out_ready;
  int         duty;
  int         low_burst;
  int         tb_errors;
  int         chk_errors;
  int         pending;

  audio_mixer_top dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .axi_req    (axi_req),
    .axi_rsp    (axi_rsp),
    .in_frame   (in_frame),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_sample (out_sample),
    .out_valid  (out_valid),
    .out_ready  (out_ready)
  );

  mixer_checker u_monitor (
    .clk (clk), .rst_n (rst_n), .axi_req (axi_req), .axi_rsp (axi_rsp),
    .in_frame (in_frame), .in_valid (in_valid), .in_ready (in_ready),
    .out_sample (out_sample), .out_valid (out_valid), .out_ready (out_ready),
    .errors (chk_errors), .pending (pending)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // out_ready drops in short low bursts
  always @(posedge clk) begin
    if (low_burst > 0) begin
      out_ready <= 1'b0;
      low_burst <= low_burst - 1;
    end else if (int'($urandom_range(99)) < duty) begin
      out_ready <= 1'b1;
    end else begin
      out_ready <= 1'b0;
      low_burst <= int'($urandom_range(2));
    end
  end

  //////////////////////////////
  // bus and stream tasks
  //////////////////////////////

  task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                           input axi4l_resp_e exp_resp);
    @(posedge clk);
    axi_req.awaddr  <= addr;
    axi_req.awvalid <= 1'b1;
    axi_req.wdata   <= data;
    axi_req.wstrb   <= '1;
    axi_req.wvalid  <= 1'b1;
    axi_req.bready  <= 1'b1;
    do @(posedge clk); while (!axi_rsp.awready);
    axi_req.awvalid <= 1'b0;
    axi_req.wvalid  <= 1'b0;
    if (axi_rsp.wready !== 1'b1) begin
      tb_errors++;
      $display("Mismatch wready at 0x%h: got 0x%h expected 0x1", addr, axi_rsp.wready);
    end
    do @(posedge clk); while (!axi_rsp.bvalid);
    axi_req.bready <= 1'b0;
    if (axi_rsp.bresp !== exp_resp) begin
      tb_errors++;
      $display("Mismatch bresp at 0x%h: got 0x%h expected 0x%h", addr, axi_rsp.bresp, exp_resp);
    end
  endtask

  task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp_data,
                          input axi4l_resp_e exp_resp);
    @(posedge clk);
    axi_req.araddr  <= addr;
    axi_req.arvalid <= 1'b1;
    axi_req.rready  <= 1'b1;
    do @(posedge clk); while (!axi_rsp.arready);
    axi_req.arvalid <= 1'b0;
    do @(posedge clk); while (!axi_rsp.rvalid);
    axi_req.rready <= 1'b0;
    if (axi_rsp.rdata !== exp_data || axi_rsp.rresp !== exp_resp) begin
      tb_errors++;
      $display("Mismatch rdata/rresp at 0x%h: got 0x%h/0x%h expected 0x%h/0x%h", addr,
               axi_rsp.rdata, axi_rsp.rresp, exp_data, exp_resp);
    end
  endtask

  task automatic stream_frames(input row_t r);
    mix_frame_t frame;
    int         v;
    int         lvl;
    lvl = int'(r.level);
    for (int k = 0; k < r.frames; k++) begin
      for (int i = 0; i < nr_channels; i++) begin
        if (r.fixed) begin
          v = (k % 2 == 0) ? lvl : -lvl;
        end else begin
          v = int'($urandom_range(2 * lvl)) - lvl;
        end
        frame.ch[i] = audio_t'(v);
      end
      in_frame <= frame;
      in_valid <= 1'b1;
      do @(posedge clk); while (!in_ready);   // accepted on this edge
    end
    in_valid <= 1'b0;
  endtask

  // wait until every accepted frame has left
  task automatic drain();
    do @(negedge clk); while (pending != 0);
    @(posedge clk);
  endtask

  task automatic check_registers();
    for (int i = 0; i < nr_channels; i++) begin
      write_reg(8'(4 * i), 32'ha5a5_0000 | (32'h1111 * (i + 1)), okay);
      read_reg(8'(4 * i), 32'h1111 * (i + 1), okay);   // upper half dropped
    end
    write_reg(reg_pan, 32'hffff_fff5, okay);
    read_reg(reg_pan, 32'h5, okay);
    write_reg(reg_out_gain, 32'h1234_0180, okay);
    read_reg(reg_out_gain, 32'h0180, okay);
    write_reg(8'h1c, 32'hffff_ffff, slverr);
    read_reg(8'h1c, 32'h0, slverr);
    write_reg(8'h40, 32'h0000_0000, slverr);
    read_reg(8'h40, 32'h0, slverr);
    read_reg(reg_pan, 32'h5, okay);   // untouched by the bad writes
    read_reg(reg_ch_gain0, 32'h1111, okay);
    read_reg(reg_status, 32'h0, okay);
  endtask

  task automatic run_row(input row_t r);
    for (int i = 0; i < nr_channels; i++) begin
      write_reg(8'(4 * i), 32'(r.gains[i]), okay);
    end
    write_reg(reg_pan, 32'(r.pan), okay);
    write_reg(reg_out_gain, 32'(r.out_gain), okay);
    duty = r.duty;
    stream_frames(r);
    drain();
    duty = 100;
    read_reg(reg_status, r.exp_status, okay);
    write_reg(reg_status, 32'h1f, okay);
    read_reg(reg_status, 32'h0, okay);
  endtask

  //////////////////////////////
  // run control
  //////////////////////////////

  function automatic int run_budget();
    int frames;
    frames = 0;
    for (int r = 0; r < nr_rows; r++) begin
      frames += rows[r].frames;
    end
    return (frames + nr_rows) * 40;
  endfunction

  initial begin
    repeat (run_budget()) @(posedge clk);
    $display("Watchdog expired after %0d cycles, errors: checker %0d, testbench %0d",
             run_budget(), chk_errors, tb_errors);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    void'($urandom(50917));
    rst_n     = 1'b0;
    axi_req   = '0;
    in_frame  = '0;
    in_valid  = 1'b0;
    out_ready = 1'b1;
    duty      = 100;
    low_burst = 0;
    tb_errors = 0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    check_registers();
    for (int r = 0; r < nr_rows; r++) begin
      run_row(rows[r]);
    end
    repeat (4) @(posedge clk);
    $display("Errors: checker %0d, testbench %0d", chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verilog/audio_mixer_top.sv
`timescale 1ns/1ps

module audio_mixer_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  axi4l_pkg::axi4l_req_t axi_req,
  output axi4l_pkg::axi4l_rsp_t axi_rsp,
  input  mixer_pkg::mix_frame_t in_frame,
  input  logic                  in_valid,
  output logic                  in_ready,
  output mixer_pkg::stereo_t    out_sample,
  output logic                  out_valid,
  input  logic                  out_ready
);

  import mixer_pkg::*;

  mix_cfg_t  cfg;         // register block to core
  mix_clip_t clip_event;  // core back to the status flags

  mixer_regs u_regs (
    .clk        (clk),
    .rst_n      (rst_n),
    .axi_req    (axi_req),
    .axi_rsp    (axi_rsp),
    .cfg        (cfg),
    .clip_event (clip_event)
  );

  mixer_core u_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_frame   (in_frame),
    .in_valid   (in_valid),
    .in_ready   (in_ready),
    .out_sample (out_sample),
    .out_valid  (out_valid),
    .out_ready  (out_ready),
    .cfg        (cfg),
    .clip_event (clip_event)
  );

endmodule

//--- verilog/axi4l_pkg.sv
package axi4l_pkg;

  localparam int axi_addr_width = 8;
  localparam int axi_data_width = 32;

  typedef enum logic [1:0] {
    okay   = 2'b00,
    slverr = 2'b10
  } axi4l_resp_e;

  // master to slave
  typedef struct packed {
    logic [axi_addr_width-1:0]   awaddr;
    logic                        awvalid;
    logic [axi_data_width-1:0]   wdata;
    logic [axi_data_width/8-1:0] wstrb;
    logic                        wvalid;
    logic                        bready;
    logic [axi_addr_width-1:0]   araddr;
    logic                        arvalid;
    logic                        rready;
  } axi4l_req_t;

  // slave to master
  typedef struct packed {
    logic                      awready;
    logic                      wready;
    axi4l_resp_e               bresp;
    logic                      bvalid;
    logic                      arready;
    logic [axi_data_width-1:0] rdata;
    axi4l_resp_e               rresp;
    logic                      rvalid;
  } axi4l_rsp_t;

endpackage

//--- verilog/mixer_channel.sv
`timescale 1ns/1ps

module mixer_channel (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               en,
  input  mixer_pkg::audio_t  x,
  input  mixer_pkg::gain_t   gain,
  input  logic               pan,
  output mixer_pkg::stereo_t y,
  output logic               clip
);

  import mixer_pkg::*;

  logic signed [sum_width-1:0] x_ext;
  audio_t                      scaled;
  logic                        scaled_ovf;

  // sign extend to the multiplier input width
  assign x_ext = {{(sum_width-audio_width){x[audio_width-1]}}, x};

  //////////////////////////////
  // gain stage
  //////////////////////////////

  nq_multiplier u_gain_mul (
    .clk          (clk),
    .rst_n        (rst_n),
    .en           (en),
    .multiplicand (x_ext),
    .multiplier   (gain),
    .product      (scaled),
    .overflow     (scaled_ovf)
  );

  //////////////////////////////
  // route stage
  //////////////////////////////

  always_ff @(posedge clk) begin
    if (en) begin
      y.left  <= pan ? '0 : scaled;   // other lane carries zero
      y.right <= pan ? scaled : '0;
    end
  end

  // clip travels with its sample
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      clip <= 1'b0;
    end else if (en) begin
      clip <= scaled_ovf;
    end
  end

endmodule

//--- verilog/mixer_core.sv
`timescale 1ns/1ps

module mixer_core (
  input  logic                  clk,
  input  logic                  rst_n,
  input  mixer_pkg::mix_frame_t in_frame,
  input  logic                  in_valid,
  output logic                  in_ready,
  output mixer_pkg::stereo_t    out_sample,
  output logic                  out_valid,
  input  logic                  out_ready,
  input  mixer_pkg::mix_cfg_t   cfg,
  output mixer_pkg::mix_clip_t  clip_event
);

  import mixer_pkg::*;

  logic [3:0]                  vld;      // bit 0 is the channel multiply stage
  logic                        advance;
  stereo_t [nr_channels-1:0]   routed;
  logic [nr_channels-1:0]      ch_clip;
  logic signed [sum_width-1:0] sum_l;
  logic signed [sum_width-1:0] sum_r;
  logic signed [sum_width-1:0] bus_l;
  logic signed [sum_width-1:0] bus_r;
  audio_t                      out_l;
  audio_t                      out_r;
  logic                        ovf_l;
  logic                        ovf_r;

  // whole pipe moves together
  assign advance   = !vld[3] || out_ready;
  assign in_ready  = advance;
  assign out_valid = vld[3];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld <= '0;
    end else if (advance) begin
      vld <= {vld[2:0], in_valid};
    end
  end

  for (genvar i = 0; i < nr_channels; i++) begin : g_ch
    mixer_channel u_ch (
      .clk   (clk),
      .rst_n (rst_n),
      .en    (advance),
      .x     (in_frame.ch[i]),
      .gain  (cfg.ch_gain[i]),
      .pan   (cfg.pan[i]),
      .y     (routed[i]),
      .clip  (ch_clip[i])
    );
  end

  //////////////////////////////
  // bus sum
  //////////////////////////////

  always_comb begin
    sum_l = '0;
    sum_r = '0;
    for (int i = 0; i < nr_channels; i++) begin
      sum_l = sum_l + routed[i].left;   // guard bits absorb four full-scale lanes
      sum_r = sum_r + routed[i].right;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      bus_l <= sum_l;
      bus_r <= sum_r;
    end
  end

  // output gain, one per bus
  nq_multiplier u_out_mul_l (
    .clk (clk), .rst_n (rst_n), .en (advance),
    .multiplicand (bus_l), .multiplier (cfg.out_gain),
    .product (out_l), .overflow (ovf_l)
  );

  nq_multiplier u_out_mul_r (
    .clk (clk), .rst_n (rst_n), .en (advance),
    .multiplicand (bus_r), .multiplier (cfg.out_gain),
    .product (out_r), .overflow (ovf_r)
  );

  assign out_sample = '{left: out_l, right: out_r};

  // one pulse per stage transfer
  assign clip_event = '{ch_clip:  ch_clip & {nr_channels{vld[1] && advance}},
                        out_clip: (ovf_l || ovf_r) && vld[3] && advance};

endmodule

//--- verilog/mixer_pkg.sv
package mixer_pkg;

  //////////////////////////////
  // audio path widths
  //////////////////////////////

  localparam int nr_channels = 4;
  localparam int audio_width = 16;
  localparam int gain_width  = 16;
  localparam int q_bits      = 8;                // fractional bits of a gain
  localparam int sum_width   = audio_width + 2;  // two guard bits on the bus sum

  typedef logic signed [audio_width-1:0] audio_t;
  typedef logic        [gain_width-1:0]  gain_t;   // unsigned q8.8

  localparam gain_t gain_unity = gain_t'(1 << q_bits);

  // one sample per channel
  typedef struct packed {
    audio_t [nr_channels-1:0] ch;
  } mix_frame_t;

  typedef struct packed {
    audio_t left;
    audio_t right;
  } stereo_t;

  typedef struct packed {
    gain_t [nr_channels-1:0] ch_gain;
    logic  [nr_channels-1:0] pan;       // 0 routes to left
    gain_t                   out_gain;
  } mix_cfg_t;

  // out_clip is the lsb, same layout as the status word
  typedef struct packed {
    logic [nr_channels-1:0] ch_clip;
    logic                   out_clip;
  } mix_clip_t;

  //////////////////////////////
  // register map
  //////////////////////////////

  typedef enum logic [7:0] {
    reg_ch_gain0 = 8'h00,
    reg_ch_gain1 = 8'h04,
    reg_ch_gain2 = 8'h08,
    reg_ch_gain3 = 8'h0C,
    reg_pan      = 8'h10,
    reg_out_gain = 8'h14,
    reg_status   = 8'h18
  } mix_reg_e;

endpackage

//--- verilog/mixer_regs.sv
`timescale 1ns/1ps

module mixer_regs (
  input  logic                  clk,
  input  logic                  rst_n,
  input  axi4l_pkg::axi4l_req_t axi_req,
  output axi4l_pkg::axi4l_rsp_t axi_rsp,
  output mixer_pkg::mix_cfg_t   cfg,
  input  mixer_pkg::mix_clip_t  clip_event
);

  import axi4l_pkg::*;
  import mixer_pkg::*;

  typedef enum logic {wr_idle, wr_resp} wr_state_e;
  typedef enum logic {rd_idle, rd_resp} rd_state_e;

  wr_state_e                 wr_state;
  rd_state_e                 rd_state;
  mix_reg_e                  wr_addr;
  mix_reg_e                  rd_addr;
  logic                      wr_fire;
  logic                      rd_fire;
  axi4l_resp_e               bresp_q;
  axi4l_resp_e               rresp_q;
  logic [axi_data_width-1:0] rdata_q;
  logic [axi_data_width-1:0] rd_word;
  mix_cfg_t                  cfg_q;
  mix_clip_t                 status_q;
  mix_clip_t                 status_clr;

  function automatic logic mapped(mix_reg_e addr);
    logic hit;
    case (addr)
      reg_ch_gain0, reg_ch_gain1, reg_ch_gain2, reg_ch_gain3,
      reg_pan, reg_out_gain, reg_status: hit = 1'b1;
      default:                           hit = 1'b0;
    endcase
    return hit;
  endfunction

  assign wr_addr = mix_reg_e'(axi_req.awaddr);
  assign rd_addr = mix_reg_e'(axi_req.araddr);

  // aw and w accepted together
  assign wr_fire = (wr_state == wr_idle) && axi_req.awvalid && axi_req.wvalid;
  assign rd_fire = (rd_state == rd_idle) && axi_req.arvalid;

  //////////////////////////////
  // write channel
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_state       <= wr_idle;
      bresp_q        <= okay;
      cfg_q.ch_gain  <= {nr_channels{gain_unity}};
      cfg_q.pan      <= '0;
      cfg_q.out_gain <= gain_unity;
    end else begin
      case (wr_state)
        wr_idle: begin
          if (wr_fire) begin
            wr_state <= wr_resp;
            if (mapped(wr_addr)) bresp_q <= okay;
            else                 bresp_q <= slverr;
            case (wr_addr)
              reg_ch_gain0, reg_ch_gain1, reg_ch_gain2, reg_ch_gain3:
                cfg_q.ch_gain[axi_req.awaddr[3:2]] <= axi_req.wdata[gain_width-1:0];
              reg_pan:      cfg_q.pan      <= axi_req.wdata[nr_channels-1:0];
              reg_out_gain: cfg_q.out_gain <= axi_req.wdata[gain_width-1:0];
              default: ;    // status cleared below
            endcase
          end
        end
        wr_resp: if (axi_req.bready) wr_state <= wr_idle;
        default: wr_state <= wr_idle;
      endcase
    end
  end

  // sticky clip flags, a new event beats the clear
  assign status_clr = (wr_fire && wr_addr == reg_status) ?
                      mix_clip_t'(axi_req.wdata[$bits(mix_clip_t)-1:0]) : '0;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      status_q <= '0;
    end else begin
      status_q <= (status_q & ~status_clr) | clip_event;
    end
  end

  //////////////////////////////
  // read channel
  //////////////////////////////

  always_comb begin
    case (rd_addr)
      reg_ch_gain0, reg_ch_gain1, reg_ch_gain2, reg_ch_gain3:
        rd_word = axi_data_width'(cfg_q.ch_gain[axi_req.araddr[3:2]]);
      reg_pan:      rd_word = axi_data_width'(cfg_q.pan);
      reg_out_gain: rd_word = axi_data_width'(cfg_q.out_gain);
      reg_status:   rd_word = axi_data_width'(status_q);
      default:      rd_word = '0;    // unmapped reads zero
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_state <= rd_idle;
      rdata_q  <= '0;
      rresp_q  <= okay;
    end else begin
      case (rd_state)
        rd_idle: begin
          if (rd_fire) begin
            rd_state <= rd_resp;
            rdata_q  <= rd_word;
            if (mapped(rd_addr)) rresp_q <= okay;
            else                 rresp_q <= slverr;
          end
        end
        rd_resp: if (axi_req.rready) rd_state <= rd_idle;
        default: rd_state <= rd_idle;
      endcase
    end
  end

  always_comb begin
    axi_rsp.awready = wr_fire;
    axi_rsp.wready  = wr_fire;
    axi_rsp.bresp   = bresp_q;
    axi_rsp.bvalid  = (wr_state == wr_resp);
    axi_rsp.arready = rd_fire;
    axi_rsp.rdata   = rdata_q;
    axi_rsp.rresp   = rresp_q;
    axi_rsp.rvalid  = (rd_state == rd_resp);
  end

  assign cfg = cfg_q;

endmodule

//--- verilog/nq_multiplier.sv
`timescale 1ns/1ps

module nq_multiplier (
  input  logic                                   clk,
  input  logic                                   rst_n,
  input  logic                                   en,
  input  logic signed [mixer_pkg::sum_width-1:0] multiplicand,
  input  mixer_pkg::gain_t                       multiplier,
  output mixer_pkg::audio_t                      product,
  output logic                                   overflow
);

  import mixer_pkg::*;

  logic signed [sum_width+gain_width:0] full;   // extra bit keeps the gain positive
  logic signed [sum_width+gain_width:0] scaled;
  audio_t                               sat;
  logic                                 sat_hit;

  always_comb begin
    full    = multiplicand * $signed({1'b0, multiplier});
    scaled  = full >>> q_bits;                  // back to the sample scale
    sat     = audio_t'(scaled);
    sat_hit = 1'b0;
    if (scaled > (2 ** (audio_width - 1)) - 1) begin
      sat     = {1'b0, {(audio_width-1){1'b1}}};  // +32767
      sat_hit = 1'b1;
    end else if (scaled < -(2 ** (audio_width - 1))) begin
      sat     = {1'b1, {(audio_width-1){1'b0}}};  // -32768
      sat_hit = 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      overflow <= 1'b0;
    end else if (en) begin
      overflow <= sat_hit;
    end
  end

  always_ff @(posedge clk) begin
    if (en) begin
      product <= sat;
    end
  end

endmodule
